//--- Bender.yml
package:
  name: core

sources:
  - common/core_pkg.sv
  - hw/register_file.sv
  - hw/instr_decode.sv
  - hw/operand_issue.sv
  - hw/shift_alu.sv
  - hw/core_top.sv
  - target: test
    files:
      - test/core_tb.sv

//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

        localparam int DATA_W    = 32;
        localparam int REG_CNT   = 16;
        localparam int REG_IDX_W = 4;
        localparam int FLAG_W    = 4;  // N, Z, C, V from the top.
        localparam int IMM_W     = 12;
        localparam int SHAMT_W   = 5;

        // Instruction fields, top bit down.
        localparam int OPCODE_LSB  = 28; // [31:28]
        localparam int S_BIT       = 27;
        localparam int IMM_SEL_BIT = 26;
        localparam int RD_LSB      = 22; // [25:22]
        localparam int RN_LSB      = 18; // [21:18]
        localparam int RM_LSB      = 7;  // [10:7]
        localparam int SHIFT_LSB   = 5;  // [6:5]
        localparam int SHAMT_LSB   = 0;  // [4:0]
        localparam int IMM_LSB     = 0;  // Overlaps rm and the shift fields.

        typedef enum logic [3:0] {
                ALU_ADD = 4'd0,
                ALU_SUB = 4'd1,
                ALU_AND = 4'd2,
                ALU_ORR = 4'd3,
                ALU_EOR = 4'd4,
                ALU_MOV = 4'd5
        } alu_op_e;

        typedef enum logic [1:0] {
                SH_LSL = 2'd0,
                SH_LSR = 2'd1,
                SH_ASR = 2'd2,
                SH_ROR = 2'd3
        } shift_op_e;

endpackage

`default_nettype wire

//--- filelist.f
common/core_pkg.sv
hw/register_file.sv
hw/instr_decode.sv
hw/operand_issue.sv
hw/shift_alu.sv
hw/core_top.sv
test/core_tb.sv

//--- hw/core_top.sv
`default_nettype none

module core_top (
        input  logic                            i_clk,
        input  logic                            i_rst_n,
        input  logic [core_pkg::DATA_W-1:0]     i_instruction,
        input  logic                            i_valid,
        output logic                            o_wb_valid,
        output logic [core_pkg::REG_IDX_W-1:0]  o_wb_index,
        output logic [core_pkg::DATA_W-1:0]     o_wb_data,
        output logic [core_pkg::FLAG_W-1:0]     o_flags
);

        import core_pkg::*;

        logic                 dec_valid;
        alu_op_e              dec_op;
        logic                 dec_set_flags;
        logic                 dec_use_imm;
        logic [REG_IDX_W-1:0] dec_rd;
        logic [REG_IDX_W-1:0] dec_rn;
        logic [REG_IDX_W-1:0] dec_rm;
        shift_op_e            dec_shift;
        logic [SHAMT_W-1:0]   dec_shamt;
        logic [DATA_W-1:0]    dec_imm;

        logic                 iss_valid;
        alu_op_e              iss_op;
        logic                 iss_set_flags;
        logic                 iss_use_imm;
        logic [REG_IDX_W-1:0] iss_rd;
        shift_op_e            iss_shift;
        logic [SHAMT_W-1:0]   iss_shamt;
        logic [DATA_W-1:0]    iss_imm;
        logic [DATA_W-1:0]    iss_op_a;
        logic [DATA_W-1:0]    iss_op_b;

        logic                 ex_nxt_valid;
        logic [REG_IDX_W-1:0] ex_nxt_rd;
        logic [DATA_W-1:0]    ex_nxt_data;

        logic [REG_IDX_W-1:0] rf_index_a;
        logic [REG_IDX_W-1:0] rf_index_b;
        logic [DATA_W-1:0]    rf_data_a;
        logic [DATA_W-1:0]    rf_data_b;

        instr_decode u_instr_decode (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_instruction  (i_instruction),
                .i_valid        (i_valid),
                .o_valid        (dec_valid),
                .o_op           (dec_op),
                .o_set_flags    (dec_set_flags),
                .o_use_imm      (dec_use_imm),
                .o_rd           (dec_rd),
                .o_rn           (dec_rn),
                .o_rm           (dec_rm),
                .o_shift        (dec_shift),
                .o_shamt        (dec_shamt),
                .o_imm          (dec_imm)
        );

        operand_issue u_operand_issue (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_valid        (dec_valid),
                .i_op           (dec_op),
                .i_set_flags    (dec_set_flags),
                .i_use_imm      (dec_use_imm),
                .i_rd           (dec_rd),
                .i_rn           (dec_rn),
                .i_rm           (dec_rm),
                .i_shift        (dec_shift),
                .i_shamt        (dec_shamt),
                .i_imm          (dec_imm),
                .i_rf_data_a    (rf_data_a),
                .i_rf_data_b    (rf_data_b),
                .i_ex_nxt_valid (ex_nxt_valid),
                .i_ex_nxt_rd    (ex_nxt_rd),
                .i_ex_nxt_data  (ex_nxt_data),
                .i_ex_valid     (o_wb_valid),
                .i_ex_rd        (o_wb_index),
                .i_ex_data      (o_wb_data),
                .o_rf_index_a   (rf_index_a),
                .o_rf_index_b   (rf_index_b),
                .o_valid        (iss_valid),
                .o_op           (iss_op),
                .o_set_flags    (iss_set_flags),
                .o_use_imm      (iss_use_imm),
                .o_rd           (iss_rd),
                .o_shift        (iss_shift),
                .o_shamt        (iss_shamt),
                .o_imm          (iss_imm),
                .o_op_a         (iss_op_a),
                .o_op_b         (iss_op_b)
        );

        shift_alu u_shift_alu (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_valid        (iss_valid),
                .i_op           (iss_op),
                .i_set_flags    (iss_set_flags),
                .i_use_imm      (iss_use_imm),
                .i_rd           (iss_rd),
                .i_shift        (iss_shift),
                .i_shamt        (iss_shamt),
                .i_imm          (iss_imm),
                .i_op_a         (iss_op_a),
                .i_op_b         (iss_op_b),
                .o_nxt_valid    (ex_nxt_valid),
                .o_nxt_rd       (ex_nxt_rd),
                .o_nxt_data     (ex_nxt_data),
                .o_valid        (o_wb_valid),   // Retire ports.
                .o_rd           (o_wb_index),
                .o_data         (o_wb_data),
                .o_flags        (o_flags)
        );

        register_file u_register_file (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_wr_en        (o_wb_valid),
                .i_wr_index     (o_wb_index),
                .i_wr_data      (o_wb_data),
                .i_rd_index_a   (rf_index_a),
                .i_rd_index_b   (rf_index_b),
                .o_rd_data_a    (rf_data_a),
                .o_rd_data_b    (rf_data_b)
        );

endmodule

`default_nettype wire

//--- hw/instr_decode.sv
`default_nettype none

module instr_decode (
        input  logic                            i_clk,
        input  logic                            i_rst_n,
        input  logic [core_pkg::DATA_W-1:0]     i_instruction,
        input  logic                            i_valid,
        output logic                            o_valid,
        output core_pkg::alu_op_e               o_op,
        output logic                            o_set_flags,
        output logic                            o_use_imm,
        output logic [core_pkg::REG_IDX_W-1:0]  o_rd,
        output logic [core_pkg::REG_IDX_W-1:0]  o_rn,
        output logic [core_pkg::REG_IDX_W-1:0]  o_rm,
        output core_pkg::shift_op_e             o_shift,
        output logic [core_pkg::SHAMT_W-1:0]    o_shamt,
        output logic [core_pkg::DATA_W-1:0]     o_imm
);

        import core_pkg::*;

        logic [$bits(alu_op_e)-1:0] opcode;
        logic                       op_defined;

        assign opcode     = i_instruction[OPCODE_LSB +: $bits(alu_op_e)];
        assign op_defined = opcode <= ALU_MOV; // Codes above MOV are undefined.

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_valid <= 1'b0;
                end else begin
                        o_valid <= i_valid && op_defined;
                end
        end

        always_ff @(posedge i_clk) begin
                o_op        <= alu_op_e'(opcode);
                o_set_flags <= i_instruction[S_BIT];
                o_use_imm   <= i_instruction[IMM_SEL_BIT];
                o_rd        <= i_instruction[RD_LSB +: REG_IDX_W];
                o_rn        <= i_instruction[RN_LSB +: REG_IDX_W];
                o_rm        <= i_instruction[RM_LSB +: REG_IDX_W];
                o_shift     <= shift_op_e'(i_instruction[SHIFT_LSB +: $bits(shift_op_e)]);
                o_shamt     <= i_instruction[SHAMT_LSB +: SHAMT_W];
                o_imm       <= {{(DATA_W-IMM_W){1'b0}}, i_instruction[IMM_LSB +: IMM_W]};
        end

        // Undefined opcodes never leave decode.
        assert property (@(posedge i_clk) disable iff (!i_rst_n)
                o_valid |-> o_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR, ALU_EOR, ALU_MOV});

endmodule

`default_nettype wire

//--- hw/operand_issue.sv
`default_nettype none

module operand_issue (
        input  logic                            i_clk,
        input  logic                            i_rst_n,
        input  logic                            i_valid,
        input  core_pkg::alu_op_e               i_op,
        input  logic                            i_set_flags,
        input  logic                            i_use_imm,
        input  logic [core_pkg::REG_IDX_W-1:0]  i_rd,
        input  logic [core_pkg::REG_IDX_W-1:0]  i_rn,
        input  logic [core_pkg::REG_IDX_W-1:0]  i_rm,
        input  core_pkg::shift_op_e             i_shift,
        input  logic [core_pkg::SHAMT_W-1:0]    i_shamt,
        input  logic [core_pkg::DATA_W-1:0]     i_imm,
        input  logic [core_pkg::DATA_W-1:0]     i_rf_data_a,
        input  logic [core_pkg::DATA_W-1:0]     i_rf_data_b,
        input  logic                            i_ex_nxt_valid,
        input  logic [core_pkg::REG_IDX_W-1:0]  i_ex_nxt_rd,
        input  logic [core_pkg::DATA_W-1:0]     i_ex_nxt_data,
        input  logic                            i_ex_valid,
        input  logic [core_pkg::REG_IDX_W-1:0]  i_ex_rd,
        input  logic [core_pkg::DATA_W-1:0]     i_ex_data,
        output logic [core_pkg::REG_IDX_W-1:0]  o_rf_index_a,
        output logic [core_pkg::REG_IDX_W-1:0]  o_rf_index_b,
        output logic                            o_valid,
        output core_pkg::alu_op_e               o_op,
        output logic                            o_set_flags,
        output logic                            o_use_imm,
        output logic [core_pkg::REG_IDX_W-1:0]  o_rd,
        output core_pkg::shift_op_e             o_shift,
        output logic [core_pkg::SHAMT_W-1:0]    o_shamt,
        output logic [core_pkg::DATA_W-1:0]     o_imm,
        output logic [core_pkg::DATA_W-1:0]     o_op_a,
        output logic [core_pkg::DATA_W-1:0]     o_op_b
);

        import core_pkg::*;

        logic              hit_nxt_a;
        logic              hit_nxt_b;
        logic              hit_ex_a;
        logic              hit_ex_b;
        logic [DATA_W-1:0] op_a;
        logic [DATA_W-1:0] op_b;

        assign o_rf_index_a = i_rn;
        assign o_rf_index_b = i_rm;

        // Youngest producer wins.
        assign hit_nxt_a = i_ex_nxt_valid && (i_ex_nxt_rd == i_rn);
        assign hit_nxt_b = i_ex_nxt_valid && (i_ex_nxt_rd == i_rm);
        assign hit_ex_a  = i_ex_valid && (i_ex_rd == i_rn);
        assign hit_ex_b  = i_ex_valid && (i_ex_rd == i_rm);

        assign op_a = hit_nxt_a ? i_ex_nxt_data : (hit_ex_a ? i_ex_data : i_rf_data_a);
        assign op_b = hit_nxt_b ? i_ex_nxt_data : (hit_ex_b ? i_ex_data : i_rf_data_b);

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_valid <= 1'b0;
                end else begin
                        o_valid <= i_valid;
                end
        end

        always_ff @(posedge i_clk) begin
                o_op        <= i_op;
                o_set_flags <= i_set_flags;
                o_use_imm   <= i_use_imm;
                o_rd        <= i_rd;
                o_shift     <= i_shift;
                o_shamt     <= i_shamt;
                o_imm       <= i_imm;
                o_op_a      <= op_a;
                o_op_b      <= op_b;
        end

        // Execute's next result belongs to the instruction issued last cycle.
        assert property (@(posedge i_clk) disable iff (!i_rst_n)
                (hit_nxt_a || hit_nxt_b) |-> o_valid);

        // A registered result was a valid next result one cycle earlier.
        assert property (@(posedge i_clk) disable iff (!i_rst_n)
                (hit_ex_a || hit_ex_b) |-> $past(i_ex_nxt_valid) && $past(i_ex_nxt_rd) == i_ex_rd);

endmodule

`default_nettype wire

//--- hw/register_file.sv
`default_nettype none

module register_file (
        input  logic                            i_clk,
        input  logic                            i_rst_n,
        input  logic                            i_wr_en,
        input  logic [core_pkg::REG_IDX_W-1:0]  i_wr_index,
        input  logic [core_pkg::DATA_W-1:0]     i_wr_data,
        input  logic [core_pkg::REG_IDX_W-1:0]  i_rd_index_a,
        input  logic [core_pkg::REG_IDX_W-1:0]  i_rd_index_b,
        output logic [core_pkg::DATA_W-1:0]     o_rd_data_a,
        output logic [core_pkg::DATA_W-1:0]     o_rd_data_b
);

        import core_pkg::*;

        logic [DATA_W-1:0] regs [REG_CNT];

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        for (int i = 0; i < REG_CNT; i++) begin
                                regs[i] <= '0;
                        end
                end else if (i_wr_en) begin
                        regs[i_wr_index] <= i_wr_data;
                end
        end

        // Older writers are covered by forwarding in issue.
        assign o_rd_data_a = regs[i_rd_index_a];
        assign o_rd_data_b = regs[i_rd_index_b];

endmodule

`default_nettype wire

//--- hw/shift_alu.sv
`default_nettype none

module shift_alu (
        input  logic                            i_clk,
        input  logic                            i_rst_n,
        input  logic                            i_valid,
        input  core_pkg::alu_op_e               i_op,
        input  logic                            i_set_flags,
        input  logic                            i_use_imm,
        input  logic [core_pkg::REG_IDX_W-1:0]  i_rd,
        input  core_pkg::shift_op_e             i_shift,
        input  logic [core_pkg::SHAMT_W-1:0]    i_shamt,
        input  logic [core_pkg::DATA_W-1:0]     i_imm,
        input  logic [core_pkg::DATA_W-1:0]     i_op_a,
        input  logic [core_pkg::DATA_W-1:0]     i_op_b,
        output logic                            o_nxt_valid,
        output logic [core_pkg::REG_IDX_W-1:0]  o_nxt_rd,
        output logic [core_pkg::DATA_W-1:0]     o_nxt_data,
        output logic                            o_valid,
        output logic [core_pkg::REG_IDX_W-1:0]  o_rd,
        output logic [core_pkg::DATA_W-1:0]     o_data,
        output logic [core_pkg::FLAG_W-1:0]     o_flags
);

        import core_pkg::*;

        logic [DATA_W:0]   lsl_ext;
        logic [DATA_W:0]   lsr_ext;
        logic [DATA_W:0]   asr_ext;
        logic [DATA_W-1:0] ror_val;
        logic [DATA_W-1:0] shifted;
        logic              shift_c;
        logic [DATA_W:0]   sum;
        logic [DATA_W-1:0] result;
        logic              c_nxt;
        logic              v_nxt;
        logic [FLAG_W-1:0] flags_nxt;

        // Extra bit catches the last bit shifted out.
        assign lsl_ext = {1'b0, i_op_b} << i_shamt;
        assign lsr_ext = {i_op_b, 1'b0} >> i_shamt;
        assign asr_ext = $signed({i_op_b, 1'b0}) >>> i_shamt;
        assign ror_val = (i_op_b >> i_shamt) | (i_op_b << (DATA_W - i_shamt));

        always_comb begin
                shifted = i_op_b;
                shift_c = o_flags[1]; // C held unless something shifts out.
                if (i_use_imm) begin
                        shifted = i_imm;
                end else if (i_shamt != '0) begin
                        unique case (i_shift)
                                SH_LSL: {shift_c, shifted} = lsl_ext;
                                SH_LSR: {shifted, shift_c} = lsr_ext;
                                SH_ASR: {shifted, shift_c} = asr_ext;
                                SH_ROR: {shift_c, shifted} = {ror_val[DATA_W-1], ror_val};
                        endcase
                end
        end

        always_comb begin
                sum    = '0;
                result = shifted;
                c_nxt  = shift_c;
                v_nxt  = o_flags[0];
                unique case (i_op)
                        ALU_ADD: begin
                                sum    = {1'b0, i_op_a} + {1'b0, shifted};
                                result = sum[DATA_W-1:0];
                                c_nxt  = sum[DATA_W];
                                v_nxt  = (i_op_a[31] == shifted[31]) && (result[31] != i_op_a[31]);
                        end
                        ALU_SUB: begin
                                sum    = {1'b0, i_op_a} + {1'b0, ~shifted} + 1'b1;
                                result = sum[DATA_W-1:0];
                                c_nxt  = sum[DATA_W]; // Not-borrow.
                                v_nxt  = (i_op_a[31] != shifted[31]) && (result[31] != i_op_a[31]);
                        end
                        ALU_AND: result = i_op_a & shifted;
                        ALU_ORR: result = i_op_a | shifted;
                        ALU_EOR: result = i_op_a ^ shifted;
                        default: result = shifted; // MOV.
                endcase
        end

        assign flags_nxt = {result[DATA_W-1], result == '0, c_nxt, v_nxt};

        assign o_nxt_valid = i_valid;
        assign o_nxt_rd    = i_rd;
        assign o_nxt_data  = result;

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_valid <= 1'b0;
                        o_flags <= '0;
                end else begin
                        o_valid <= i_valid;
                        if (i_valid && i_set_flags) begin
                                o_flags <= flags_nxt;
                        end
                end
        end

        always_ff @(posedge i_clk) begin
                o_rd   <= i_rd;
                o_data <= result;
        end

        assert property (@(posedge i_clk) disable iff (!i_rst_n)
                !$stable(o_flags) |-> $past(i_valid && i_set_flags));

endmodule

`default_nettype wire

//--- test/core_tb.sv
`default_nettype none

module core_tb;

        import core_pkg::*;

        localparam int CLK_PERIOD   = 8;
        localparam int RESET_CYCLES = 5;
        localparam int TEST_CYCLES  = 400;
        localparam int DRAIN_CYCLES = 4;  // Pipeline depth plus the register write.
        localparam int PIPE_DEPTH   = 3;
        localparam int WATCHDOG_T   =
                (RESET_CYCLES + TEST_CYCLES + DRAIN_CYCLES + 20) * CLK_PERIOD;

        logic                 clk;
        logic                 rst_n;
        logic [DATA_W-1:0]    instruction;
        logic                 valid;
        logic                 wb_valid;
        logic [REG_IDX_W-1:0] wb_index;
        logic [DATA_W-1:0]    wb_data;
        logic [FLAG_W-1:0]    flags;

        logic [31:0]          rand_state;
        logic [DATA_W-1:0]    model_regs [REG_CNT];
        logic [FLAG_W-1:0]    model_flags;

        // Expected retirement of the instruction driven this cycle.
        logic                 drv_valid;
        logic [REG_IDX_W-1:0] drv_index;
        logic [DATA_W-1:0]    drv_data;
        logic [FLAG_W-1:0]    drv_flags;

        logic                 exp_valid [PIPE_DEPTH];
        logic [REG_IDX_W-1:0] exp_index [PIPE_DEPTH];
        logic [DATA_W-1:0]    exp_data  [PIPE_DEPTH];
        logic [FLAG_W-1:0]    exp_flags [PIPE_DEPTH];

        core_top core_top_i (
                .i_clk          (clk),
                .i_rst_n        (rst_n),
                .i_instruction  (instruction),
                .i_valid        (valid),
                .o_wb_valid     (wb_valid),
                .o_wb_index     (wb_index),
                .o_wb_data      (wb_data),
                .o_flags        (flags)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < PIPE_DEPTH; i++) begin
                                exp_valid[i] <= 1'b0;
                                exp_index[i] <= '0;
                                exp_data[i]  <= '0;
                                exp_flags[i] <= '0;
                        end
                end else begin
                        exp_valid[0] <= drv_valid;
                        exp_index[0] <= drv_index;
                        exp_data[0]  <= drv_data;
                        exp_flags[0] <= drv_flags;
                        for (int i = 1; i < PIPE_DEPTH; i++) begin
                                exp_valid[i] <= exp_valid[i-1];
                                exp_index[i] <= exp_index[i-1];
                                exp_data[i]  <= exp_data[i-1];
                                exp_flags[i] <= exp_flags[i-1];
                        end
                end
        end

        function automatic logic [31:0] next_rand();
                rand_state = rand_state * 32'd1664525 + 32'd1013904223;
                return {rand_state[15:0], rand_state[31:16]}; // Low state bits are weak.
        endfunction

        // Mostly r0..r3, so that neighbours depend on each other.
        function automatic logic [REG_IDX_W-1:0] pick_reg(input logic [7:0] bits);
                if (bits[7:5] == 3'd0) begin
                        return bits[3:0];
                end
                return {2'b00, bits[1:0]};
        endfunction

        // Returns {carry, value}.
        function automatic logic [32:0] shift_model(input logic [31:0] b, input shift_op_e kind,
                                                    input logic [4:0] n, input logic carry_in);
                int          amt;
                logic [31:0] val;
                logic        c;
                amt = n;
                val = b;
                c   = carry_in;
                if (amt != 0) begin
                        case (kind)
                                SH_LSL: begin
                                        val = b << amt;
                                        c   = b[32 - amt];
                                end
                                SH_LSR: begin
                                        val = b >> amt;
                                        c   = b[amt - 1];
                                end
                                SH_ASR: begin
                                        val = $signed(b) >>> amt;
                                        c   = b[amt - 1];
                                end
                                default: begin
                                        val = (b >> amt) | (b << (32 - amt));
                                        c   = b[amt - 1];
                                end
                        endcase
                end
                return {c, val};
        endfunction

        task automatic run_model(input logic [31:0] instr, output logic [31:0] result);
                alu_op_e     op;
                logic [31:0] a;
                logic [31:0] op2;
                logic [32:0] sh;
                logic        c;
                logic        v;
                longint      sa;
                longint      sb;
                op = alu_op_e'(instr[OPCODE_LSB +: 4]);
                a  = model_regs[instr[RN_LSB +: REG_IDX_W]];
                if (instr[IMM_SEL_BIT]) begin
                        sh = {model_flags[1], 20'd0, instr[IMM_LSB +: IMM_W]};
                end else begin
                        sh = shift_model(model_regs[instr[RM_LSB +: REG_IDX_W]],
                                         shift_op_e'(instr[SHIFT_LSB +: 2]),
                                         instr[SHAMT_LSB +: SHAMT_W], model_flags[1]);
                end
                op2 = sh[31:0];
                c   = sh[32];
                v   = model_flags[0];
                sa  = $signed(a);
                sb  = $signed(op2);
                case (op)
                        ALU_ADD: begin
                                result = a + op2;
                                c      = result < a; // Sum wrapped past the top.
                                v      = sa + sb != longint'($signed(result));
                        end
                        ALU_SUB: begin
                                result = a - op2;
                                c      = a >= op2; // No borrow.
                                v      = sa - sb != longint'($signed(result));
                        end
                        ALU_AND: result = a & op2;
                        ALU_ORR: result = a | op2;
                        ALU_EOR: result = a ^ op2;
                        default: result = op2;
                endcase
                model_regs[instr[RD_LSB +: REG_IDX_W]] = result;
                if (instr[S_BIT]) begin
                        model_flags = {result[31], result == 32'd0, c, v};
                end
        endtask

        task automatic drive_cycle();
                logic [31:0]          r;
                logic [31:0]          r2;
                logic [31:0]          instr;
                logic [31:0]          result;
                logic [3:0]           op;
                logic [REG_IDX_W-1:0] rd;
                logic                 is_valid;
                r     = next_rand();
                r2    = next_rand();
                instr = next_rand();
                if (r[7:4] == 4'd0) begin
                        op = 4'd6 + r[11:8] % 4'd10; // Undefined code.
                end else begin
                        op = r[3:0] % 4'd6;
                end
                is_valid = r[15:13] != 3'd0;
                rd       = pick_reg(r[23:16]);
                instr[OPCODE_LSB +: 4]      = op;
                instr[RD_LSB +: REG_IDX_W]  = rd;
                instr[RN_LSB +: REG_IDX_W]  = pick_reg(r[31:24]);
                if (!instr[IMM_SEL_BIT]) begin
                        instr[RM_LSB +: REG_IDX_W] = pick_reg(r2[7:0]);
                end
                @(negedge clk);
                instruction = instr;
                valid       = is_valid;
                drv_valid   = 1'b0;
                if (is_valid && op <= 4'd5) begin
                        run_model(instr, result);
                        drv_valid = 1'b1;
                        drv_index = rd;
                        drv_data  = result;
                end
                drv_flags = model_flags;
        endtask

        task automatic report_value(input string name, input logic [31:0] got,
                                    input logic [31:0] exp);
                $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
                $display("Something failed");
                $fatal(1);
        endtask

        assert property (@(posedge clk) disable iff (!rst_n) wb_valid == exp_valid[2])
                else report_value("o_wb_valid", $sampled(wb_valid), $sampled(exp_valid[2]));

        assert property (@(posedge clk) disable iff (!rst_n)
                exp_valid[2] |-> wb_index == exp_index[2])
                else report_value("o_wb_index", $sampled(wb_index), $sampled(exp_index[2]));

        assert property (@(posedge clk) disable iff (!rst_n)
                exp_valid[2] |-> wb_data == exp_data[2])
                else report_value("o_wb_data", $sampled(wb_data), $sampled(exp_data[2]));

        // Flags hold across idle cycles and instructions without S.
        assert property (@(posedge clk) disable iff (!rst_n) flags == exp_flags[2])
                else report_value("o_flags", $sampled(flags), $sampled(exp_flags[2]));

        initial begin
                #(WATCHDOG_T);
                $display("Watchdog expired before the test sequence completed");
                $display("Something failed");
                $fatal(1);
        end

        initial begin
                rand_state  = 32'h9b9b;
                rst_n       = 1'b0;
                instruction = '0;
                valid       = 1'b0;
                drv_valid   = 1'b0;
                drv_index   = '0;
                drv_data    = '0;
                drv_flags   = '0;
                model_flags = '0;
                for (int i = 0; i < REG_CNT; i++) begin
                        model_regs[i] = '0;
                end
                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;

                repeat (TEST_CYCLES) drive_cycle();
                @(negedge clk);
                valid     = 1'b0;
                drv_valid = 1'b0;
                repeat (DRAIN_CYCLES) @(negedge clk);

                for (int i = 0; i < REG_CNT; i++) begin
                        assert (core_top_i.u_register_file.regs[i] === model_regs[i])
                                else report_value($sformatf("regs[%0d]", i),
                                                  core_top_i.u_register_file.regs[i],
                                                  model_regs[i]);
                end
                $display("Everything OK");
                $finish;
        end

endmodule

`default_nettype wire
